/* src/cpu_bus_pkg.sv */
`default_nettype none

package cpu_bus_pkg;

   localparam int ROM_WORDS = 4096;
   localparam int ROM_AW = $clog2(ROM_WORDS);

   localparam int SP_WORDS = 128;
   localparam int SP_AW = $clog2(SP_WORDS);
   localparam logic [14:0] SP_BASE = 15'h4000; // byte 0x8000
   localparam int SP_MIRROR_WORDS = 512;

   localparam logic [15:0] OPEN_BUS = 16'hffff;

   // one CPU memory cycle
   typedef struct packed {
      logic        memen;
      logic        we;
      logic        dbin;
      logic [14:0] a;  // word address
      logic [15:0] q;  // write data
   } cpu_bus_t;

   typedef struct packed {
      logic romen;
      logic spen;
      logic open;
   } bus_sel_t;

endpackage

`default_nettype wire

/* src/host_bus_pkg.sv */
`default_nettype none

package host_bus_pkg;

   // region is adr[23:16]
   localparam logic [7:0] HOST_REGION_ROM = 8'h00;
   localparam logic [7:0] HOST_REGION_SP = 8'h01;

   typedef struct packed {
      logic [23:0] adr;
      logic [7:0]  dat;
      logic        we;
      logic        stb;
      logic        cyc;
   } host_req_t;

   typedef struct packed {
      logic [7:0] dat;
      logic       ack;
   } host_rsp_t;

   // single-cycle strobe into one memory, byte offset big-endian
   typedef struct packed {
      logic        stb;
      logic        we;
      logic [15:0] ofs;
      logic [7:0]  dat;
   } host_mem_req_t;

endpackage

`default_nettype wire

/* src/address_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module address_decoder import cpu_bus_pkg::*; (
   input  cpu_bus_t cpu_i,
   output bus_sel_t sel_o
);

   localparam logic [14:0] ROM_END = 15'(ROM_WORDS);
   localparam logic [14:0] SP_END = SP_BASE + 15'(SP_MIRROR_WORDS);

   logic rom_hit;
   logic sp_hit;

   assign rom_hit = cpu_i.a < ROM_END;
   // 512 words, scratchpad repeats every 128
   assign sp_hit = (cpu_i.a >= SP_BASE) && (cpu_i.a < SP_END);

   always_comb begin
      sel_o.romen = cpu_i.memen & rom_hit;
      sel_o.spen = cpu_i.memen & sp_hit;
      sel_o.open = cpu_i.memen & ~rom_hit & ~sp_hit; // nothing answers
   end

endmodule

`default_nettype wire

/* src/console_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module console_rom import cpu_bus_pkg::*, host_bus_pkg::*; (
   input  logic          clk,
   input  cpu_bus_t      cpu_i,
   input  bus_sel_t      sel_i,
   output logic [15:0]   d_o,
   input  host_mem_req_t host_i,
   output logic [7:0]    host_dat_o
);

   logic [15:0] mem [ROM_WORDS];

   logic [ROM_AW-1:0] cpu_idx;
   logic [ROM_AW-1:0] host_idx;
   logic              host_lo;

   assign cpu_idx = cpu_i.a[ROM_AW-1:0];
   assign host_idx = host_i.ofs[ROM_AW:1];
   assign host_lo = host_i.ofs[0]; // odd byte is the low half

   // cpu side is read only
   always_ff @(posedge clk) begin
      if (sel_i.romen) begin
         d_o <= mem[cpu_idx];
      end
   end

   // host load and readback, one byte per strobe
   always_ff @(posedge clk) begin
      if (host_i.stb) begin
         if (host_i.we) begin
            if (host_lo) begin
               mem[host_idx][7:0] <= host_i.dat;
            end else begin
               mem[host_idx][15:8] <= host_i.dat;
            end
         end
         host_dat_o <= host_lo ? mem[host_idx][7:0] : mem[host_idx][15:8];
      end
   end

endmodule

`default_nettype wire

/* src/scratchpad_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module scratchpad_ram import cpu_bus_pkg::*, host_bus_pkg::*; (
   input  logic          clk,
   input  cpu_bus_t      cpu_i,
   input  bus_sel_t      sel_i,
   output logic [15:0]   d_o,
   input  host_mem_req_t host_i,
   output logic [7:0]    host_dat_o
);

   logic [15:0] mem [SP_WORDS];

   logic [SP_AW-1:0] cpu_idx;
   logic [SP_AW-1:0] host_idx;
   logic             cpu_wr;
   logic             host_wr;

   // low bits only, so the window mirrors
   assign cpu_idx = cpu_i.a[SP_AW-1:0];
   assign host_idx = host_i.ofs[SP_AW:1];
   assign cpu_wr = sel_i.spen & cpu_i.we;
   assign host_wr = host_i.stb & host_i.we & ~(cpu_wr && (cpu_idx == host_idx));

   always_ff @(posedge clk) begin
      if (cpu_wr) begin
         mem[cpu_idx] <= cpu_i.q;
      end
      if (host_wr) begin
         if (host_i.ofs[0]) begin
            mem[host_idx][7:0] <= host_i.dat;
         end else begin
            mem[host_idx][15:8] <= host_i.dat;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sel_i.spen) begin
         d_o <= mem[cpu_idx];
      end
      if (host_i.stb) begin
         host_dat_o <= host_i.ofs[0] ? mem[host_idx][7:0] : mem[host_idx][15:8];
      end
   end

endmodule

`default_nettype wire

/* src/read_data_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module read_data_merge import cpu_bus_pkg::*; (
   input  logic        clk,
   input  logic        reset_i,
   input  cpu_bus_t    cpu_i,
   input  bus_sel_t    sel_i,
   input  logic [15:0] rom_d_i,
   input  logic [15:0] sp_d_i,
   output logic [15:0] d_o
);

   logic rom_valid;
   logic sp_valid;

   // valid lines up with the synchronous memory read
   always_ff @(posedge clk) begin
      if (reset_i) begin
         rom_valid <= 1'b0;
         sp_valid <= 1'b0;
      end else begin
         rom_valid <= cpu_i.dbin & sel_i.romen;
         sp_valid <= cpu_i.dbin & sel_i.spen;
      end
   end

   // idle sources float high, open reads fall out as OPEN_BUS
   assign d_o = OPEN_BUS &
                (rom_valid ? rom_d_i : OPEN_BUS) &
                (sp_valid ? sp_d_i : OPEN_BUS);

endmodule

`default_nettype wire

/* src/host_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module host_bridge import host_bus_pkg::*; (
   input  logic          clk,
   input  logic          reset_i,
   input  host_req_t     host_i,
   output host_rsp_t     host_o,
   output host_mem_req_t rom_req_o,
   output host_mem_req_t sp_req_o,
   input  logic [7:0]    rom_dat_i,
   input  logic [7:0]    sp_dat_i
);

   logic [7:0] region;
   logic [7:0] region_q;
   logic       active;
   logic       acked;
   logic       start;
   logic       ack_q;

   assign region = host_i.adr[23:16];
   assign active = host_i.stb & host_i.cyc;
   assign start = active & ~acked; // first stb cycle only

   always_comb begin
      rom_req_o.stb = start && (region == HOST_REGION_ROM);
      rom_req_o.we = host_i.we;
      rom_req_o.ofs = host_i.adr[15:0];
      rom_req_o.dat = host_i.dat;
      sp_req_o.stb = start && (region == HOST_REGION_SP);
      sp_req_o.we = host_i.we;
      sp_req_o.ofs = host_i.adr[15:0];
      sp_req_o.dat = host_i.dat;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         acked <= 1'b0;
      end else begin
         ack_q <= start;
         acked <= active; // cleared once stb drops
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         region_q <= region;
      end
   end

   always_comb begin
      host_o.ack = ack_q;
      case (region_q)
         HOST_REGION_ROM: host_o.dat = rom_dat_i;
         HOST_REGION_SP:  host_o.dat = sp_dat_i;
         default:         host_o.dat = 8'h00; // unmapped
      endcase
   end

endmodule

`default_nettype wire

/* src/mainboard.sv */
`timescale 1ns/1ps
`default_nettype none

module mainboard import cpu_bus_pkg::*, host_bus_pkg::*; (
   input  logic        clk,
   input  logic        reset_i,
   input  cpu_bus_t    cpu_i,
   output logic [15:0] d_o,
   input  host_req_t   host_i,
   output host_rsp_t   host_o
);

   bus_sel_t      sel;
   logic [15:0]   d_rom;
   logic [15:0]   d_sp;
   host_mem_req_t rom_req;
   host_mem_req_t sp_req;
   logic [7:0]    rom_host_dat;
   logic [7:0]    sp_host_dat;

   address_decoder addr_dec (
      .cpu_i (cpu_i),
      .sel_o (sel)
   );

   console_rom rom (
      .clk        (clk),
      .cpu_i      (cpu_i),
      .sel_i      (sel),
      .d_o        (d_rom),
      .host_i     (rom_req),
      .host_dat_o (rom_host_dat)
   );

   scratchpad_ram ram (
      .clk        (clk),
      .cpu_i      (cpu_i),
      .sel_i      (sel),
      .d_o        (d_sp),
      .host_i     (sp_req),
      .host_dat_o (sp_host_dat)
   );

   read_data_merge merge (
      .clk     (clk),
      .reset_i (reset_i),
      .cpu_i   (cpu_i),
      .sel_i   (sel),
      .rom_d_i (d_rom),
      .sp_d_i  (d_sp),
      .d_o     (d_o)
   );

   host_bridge bridge (
      .clk       (clk),
      .reset_i   (reset_i),
      .host_i    (host_i),
      .host_o    (host_o),
      .rom_req_o (rom_req),
      .sp_req_o  (sp_req),
      .rom_dat_i (rom_host_dat),
      .sp_dat_i  (sp_host_dat)
   );

endmodule

`default_nettype wire

/* verif/mainboard_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mainboard_properties import cpu_bus_pkg::*, host_bus_pkg::*; (
   input logic        clk,
   input logic        reset_i,
   input cpu_bus_t    cpu_i,
   input logic [15:0] d_i,
   input host_req_t   host_i,
   input host_rsp_t   host_rsp_i
);

   logic req;

   assign req = host_i.stb & host_i.cyc;

   ack_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
      host_rsp_i.ack |=> !host_rsp_i.ack)
      else $error("host ack held longer than one cycle");

   ack_after_stb: assert property (@(posedge clk) disable iff (reset_i)
      $rose(req) |=> host_rsp_i.ack)
      else $error("no host ack one cycle after stb rose");

   idle_bus: assert property (@(posedge clk) disable iff (reset_i)
      !(cpu_i.memen && cpu_i.dbin) |=> d_i == OPEN_BUS)
      else $error("read bus not all ones after a cycle with no read");

endmodule

bind mainboard mainboard_properties mainboard_props (
   .clk        (clk),
   .reset_i    (reset_i),
   .cpu_i      (cpu_i),
   .d_i        (d_o),
   .host_i     (host_i),
   .host_rsp_i (host_o)
);

`default_nettype wire

/* verif/tb_mainboard.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mainboard import cpu_bus_pkg::*, host_bus_pkg::*; ();

   localparam int CLK_PERIOD = 40;

   typedef enum logic [2:0] {IDLE, HOST_WR, HOST_RD, CPU_WR, CPU_RD, COLLIDE} op_kind_t;
   typedef struct packed {
      op_kind_t    kind;
      logic [23:0] addr;  // host byte address or cpu word address
      logic [15:0] data;
      logic [15:0] expected;
   } op_t;

   logic        clk;
   logic        reset_i;
   cpu_bus_t    cpu_i;
   host_req_t   host_i;
   logic [15:0] d_o;
   host_rsp_t   host_o;
   op_t         ops[$];
   int          table_len = 0;
   int          checks = 0;
   int          errors = 0;
   logic [31:0] lfsr = 32'hae84_1502;
   logic [7:0]  shadow [logic [23:0]];  // keyed by host byte address

   mainboard mainboard_inst (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [15:0] lfsr_word();
      logic [15:0] w;
      w = '0;
      for (int i = 0; i < 16; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         w = {w[14:0], lfsr[0]};
      end
      return w;
   endfunction

   function automatic bit in_sp(logic [14:0] a);
      return a >= SP_BASE && a < SP_BASE + 15'(SP_MIRROR_WORDS);
   endfunction

   // host address of the high byte behind a cpu word
   function automatic logic [23:0] byte_adr(logic [14:0] a);
      if (a < 15'(ROM_WORDS)) return {HOST_REGION_ROM, a, 1'b0};
      return {HOST_REGION_SP, 8'h00, a[SP_AW-1:0], 1'b0};  // mirrors fold together
   endfunction

   function automatic logic [15:0] model_word(logic [14:0] a);
      if (a < 15'(ROM_WORDS) || in_sp(a)) return {shadow[byte_adr(a)], shadow[byte_adr(a) | 1]};
      return OPEN_BUS;
   endfunction

   task automatic host_op(op_kind_t kind, logic [23:0] adr, logic [7:0] dat);
      logic [7:0] exp;
      if (kind == HOST_WR) shadow[adr] = dat;
      exp = 8'h00;  // unmapped
      if (adr[23:16] inside {HOST_REGION_ROM, HOST_REGION_SP}) exp = shadow[adr];
      ops.push_back('{kind, adr, {8'h00, dat}, {8'h00, exp}});
   endtask

   task automatic cpu_op(op_kind_t kind, logic [14:0] a, logic [15:0] q);
      if (kind inside {CPU_WR, COLLIDE} && in_sp(a)) begin
         shadow[byte_adr(a)] = q[15:8];
         shadow[byte_adr(a) | 1] = q[7:0];
      end
      ops.push_back('{kind, 24'(a), q, model_word(a)});
   endtask

   task automatic check(logic [31:0] got, logic [31:0] exp, string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic host_cycle(logic [23:0] adr, logic [7:0] dat, logic we, logic [7:0] exp);
      int waited;
      waited = 0;
      host_i = '{adr: adr, dat: dat, we: we, stb: 1'b1, cyc: 1'b1};
      do begin
         @(negedge clk);
         cpu_i = '0;  // cpu side of a collision lasts one clock
         waited++;
      end while (!host_o.ack && waited < 4);
      check(waited, 1, "host ack delay");
      if (!we) check(host_o.dat, exp, "host read data");
      @(negedge clk);
      check(host_o.ack, 0, "host ack repeated while stb held");
      host_i = '0;
      @(negedge clk);
   endtask

   task automatic apply_op(op_t op);
      logic cpu_cycle;
      cpu_cycle = op.kind inside {CPU_WR, CPU_RD, COLLIDE};
      cpu_i = '{memen: cpu_cycle, we: cpu_cycle && op.kind != CPU_RD, dbin: op.kind == CPU_RD,
                a: op.addr[14:0], q: op.data};
      case (op.kind)
         HOST_WR, HOST_RD: host_cycle(op.addr, op.data[7:0], op.kind == HOST_WR,
                                      op.expected[7:0]);
         COLLIDE: host_cycle({HOST_REGION_SP, 8'h00, op.addr[SP_AW-1:0], 1'b0},
                             ~op.data[15:8], 1'b1, 8'h00);  // host byte should be lost
         default: begin
            @(negedge clk);
            cpu_i = '0;
            if (op.kind != CPU_WR) check(d_o, op.expected, "cpu read bus");
         end
      endcase
   endtask

   task automatic fill_table();
      logic [14:0] a;
      logic [15:0] w;
      for (int i = 0; i < 4; i++) begin
         a = 15'(i * 1365);  // both ends of rom and two inside
         w = {a[7:0] ^ 8'h3c, a[11:4] ^ 8'ha5};
         host_op(HOST_WR, {HOST_REGION_ROM, a, 1'b0}, w[15:8]);
         host_op(HOST_WR, {HOST_REGION_ROM, a, 1'b1}, w[7:0]);
         cpu_op(CPU_RD, a, '0);
      end
      cpu_op(CPU_WR, 15'd1365, 16'h1234);  // rom keeps its word
      cpu_op(CPU_RD, 15'd1365, '0);
      for (int i = 0; i < 6; i++) begin
         a = SP_BASE + 15'(i * 21);
         cpu_op(CPU_WR, a, lfsr_word());
         for (int m = 0; m < 4; m++) cpu_op(CPU_RD, a + 15'(m * SP_WORDS), '0);
      end
      cpu_op(IDLE, 15'h2000, '0);
      cpu_op(CPU_RD, 15'h2000, '0);
      cpu_op(CPU_RD, SP_BASE + 15'(SP_MIRROR_WORDS), '0);  // just past the last mirror
      host_op(HOST_RD, {HOST_REGION_ROM, 16'h1fff}, '0);
      host_op(HOST_RD, {HOST_REGION_SP, 16'h002a}, '0);
      host_op(HOST_RD, 24'h05_0010, '0);
      a = SP_BASE + 15'd42;
      cpu_op(COLLIDE, a, lfsr_word());
      cpu_op(CPU_RD, a + 15'(2 * SP_WORDS), '0);
      host_op(HOST_RD, {HOST_REGION_SP, 16'h0054}, '0);
   endtask

   initial begin
      reset_i = 1'b1;
      cpu_i = '0;
      host_i = '0;
      fill_table();
      table_len = ops.size();
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;
      check(host_o.ack, 0, "ack after reset");
      check(d_o, OPEN_BUS, "read bus after reset");
      foreach (ops[i]) apply_op(ops[i]);
      $display("%0d checks run, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // no op needs more than a few clocks
   initial begin
      wait (table_len > 0);
      #(table_len * 10 * CLK_PERIOD);
      $display("timeout: the stimulus table did not finish in time");
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
src/cpu_bus_pkg.sv
src/host_bus_pkg.sv
src/address_decoder.sv
src/console_rom.sv
src/scratchpad_ram.sv
src/read_data_merge.sv
src/host_bridge.sv
src/mainboard.sv
verif/mainboard_properties.sv
verif/tb_mainboard.sv

/* Bender.yml */
package:
  name: mainboard

sources:
  - src/cpu_bus_pkg.sv
  - src/host_bus_pkg.sv
  - src/address_decoder.sv
  - src/console_rom.sv
  - src/scratchpad_ram.sv
  - src/read_data_merge.sv
  - src/host_bridge.sv
  - src/mainboard.sv
  - target: test
    files:
      - verif/mainboard_properties.sv
      - verif/tb_mainboard.sv
